// ==== backing_ram.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module backing_ram (
    input  logic                     clk,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic                     we,
    input  logic [`CACHE_DATA_W-1:0] w_data,
    output logic [`CACHE_DATA_W-1:0] r_data
);

    localparam int unsigned WORD_ADDR_W = `CACHE_ADDR_W - `CACHE_BYTE_OFF_W;

    logic [`CACHE_DATA_W-1:0] mem [`CACHE_RAM_WORDS];
    logic [WORD_ADDR_W-1:0]   word_addr;

    // byte address to word address
    assign word_addr = addr[`CACHE_ADDR_W-1:`CACHE_BYTE_OFF_W];

    // start with all words zero
    initial begin
        for (int i = 0; i < `CACHE_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_addr] <= w_data;
        end
    end

    assign r_data = mem[word_addr];

endmodule

// ==== cache_ctrl_fsm.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         mem_valid,
    input  cache_pkg::cpu_req_t          mem_req,
    input  logic                         hit,
    input  logic [`CACHE_DATA_W-1:0]     hit_data,
    input  logic [`CACHE_DATA_W-1:0]     ram_r_data,
    input  logic [`CACHE_WORD_POS_W-1:0] word_pos,
    input  logic                         last,
    output logic                         cnt_start,
    output logic                         cnt_step,
    output cache_pkg::fill_t             fill,
    output logic [`CACHE_ADDR_W-1:0]     ram_addr,
    output logic                         ram_we,
    output logic [`CACHE_DATA_W-1:0]     ram_w_data,
    output logic [`CACHE_DATA_W-1:0]     mem_r_data,
    output logic                         mem_ready,
    output logic                         cache_hit
);

    cache_pkg::ctrl_state_t state;

    cache_pkg::cache_addr_u       req_addr;
    cache_pkg::cache_addr_u       line_base;
    cache_pkg::cache_addr_u       base_q;
    cache_pkg::cache_addr_u       fill_addr;
    logic [`CACHE_WORD_POS_W-1:0] req_word;

    logic idle_acc;
    logic rd_hit_acc;
    logic rd_miss_acc;

    assign req_addr.flat = mem_req.addr;

    assign idle_acc    = (state == cache_pkg::st_idle) && mem_valid;
    assign rd_hit_acc  = idle_acc && !mem_req.we && hit;
    assign rd_miss_acc = idle_acc && !mem_req.we && !hit;

    // line base is the request with the offset bits cleared
    always_comb begin
        line_base                 = req_addr;
        line_base.fields.word_off = '0;
        line_base.fields.byte_off = '0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= cache_pkg::st_idle;
            mem_ready <= 1'b0;
            cache_hit <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            cache_hit <= 1'b0;
            case (state)
                cache_pkg::st_idle: begin
                    if (idle_acc && mem_req.we) begin
                        // write goes to RAM this edge
                        mem_ready <= 1'b1;
                    end else if (rd_hit_acc) begin
                        mem_ready <= 1'b1;
                        cache_hit <= 1'b1;
                    end else if (rd_miss_acc) begin
                        state <= cache_pkg::st_fill;
                    end
                end
                cache_pkg::st_fill: begin
                    if (last) begin
                        state     <= cache_pkg::st_idle;
                        mem_ready <= 1'b1;
                    end
                end
                default: state <= cache_pkg::st_idle;
            endcase
        end
    end

    // miss bookkeeping and returned read word
    always_ff @(posedge clk) begin
        if (rd_hit_acc) begin
            mem_r_data <= hit_data;
        end
        if (rd_miss_acc) begin
            base_q   <= line_base;
            req_word <= req_addr.fields.word_off;
        end
        if (state == cache_pkg::st_fill && word_pos == req_word) begin
            mem_r_data <= ram_r_data;
        end
    end

    assign cnt_start = rd_miss_acc;
    assign cnt_step  = (state == cache_pkg::st_fill);

    // RAM follows the request in idle, the fill walk otherwise
    always_comb begin
        fill_addr                 = base_q;
        fill_addr.fields.word_off = word_pos;
        if (state == cache_pkg::st_fill) begin
            ram_addr = fill_addr.flat;
        end else begin
            ram_addr = mem_req.addr;
        end
    end

    assign ram_we     = idle_acc && mem_req.we;
    assign ram_w_data = mem_req.w_data;

    always_comb begin
        fill.en   = (state == cache_pkg::st_fill);
        fill.base = base_q.flat;
        fill.pos  = word_pos;
        fill.data = ram_r_data;
        fill.last = last;
    end

endmodule

// ==== cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// word and address widths
`define CACHE_DATA_W      32
`define CACHE_ADDR_W      12

// cache geometry
`define CACHE_LINE_WORDS  4
`define CACHE_WAYS        2
`define CACHE_SETS        32

// byte address split, all derived from the values above
`define CACHE_BYTE_OFF_W  $clog2(`CACHE_DATA_W / 8)
`define CACHE_OFFSET_W    $clog2(`CACHE_LINE_WORDS * (`CACHE_DATA_W / 8))
`define CACHE_WORD_POS_W  (`CACHE_OFFSET_W - `CACHE_BYTE_OFF_W)
`define CACHE_INDEX_W     $clog2(`CACHE_SETS)
`define CACHE_TAG_W       (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

// backing RAM depth in words (4 KB byte space)
`define CACHE_RAM_WORDS   (1 << (`CACHE_ADDR_W - `CACHE_BYTE_OFF_W))

`endif

// ==== cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

    // one request from the processor side
    typedef struct packed {
        logic                     we;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] w_data;
    } cpu_req_t;

    // byte address split into cache fields, msb first
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]      tag;
        logic [`CACHE_INDEX_W-1:0]    set_idx;
        logic [`CACHE_WORD_POS_W-1:0] word_off;
        logic [`CACHE_BYTE_OFF_W-1:0] byte_off;
    } addr_fields_t;

    // same address seen flat or as tag/index/offset
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] flat;
        addr_fields_t             fields;
    } cache_addr_u;

    // one fill word from the controller into the cache
    typedef struct packed {
        logic                         en;
        logic [`CACHE_ADDR_W-1:0]     base;
        logic [`CACHE_WORD_POS_W-1:0] pos;
        logic [`CACHE_DATA_W-1:0]     data;
        logic                         last;
    } fill_t;

    // controller states
    typedef enum logic {
        st_idle = 1'b0,
        st_fill = 1'b1
    } ctrl_state_t;

endpackage

// ==== fill_counter.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module fill_counter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         step,
    output logic [`CACHE_WORD_POS_W-1:0] word_pos,
    output logic                         last
);

    localparam int unsigned POS_W = `CACHE_WORD_POS_W;

    // position of the final word in a line
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(`CACHE_LINE_WORDS - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_pos <= '0;
        end else if (start) begin
            // new miss, begin at word 0 of the line
            word_pos <= '0;
        end else if (step) begin
            // wraps back to 0 after the last word
            word_pos <= word_pos + 1'b1;
        end
    end

    assign last = (word_pos == LAST_POS);

endmodule

// ==== l1_cache_2way.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module l1_cache_2way (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_valid,
    input  cache_pkg::cpu_req_t      mem_req,
    output logic                     hit,
    output logic [`CACHE_DATA_W-1:0] hit_data,
    input  cache_pkg::fill_t         fill
);

    // tag and data storage, one slice per way
    logic [`CACHE_TAG_W-1:0]  tag_mem  [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_DATA_W-1:0] data_mem [`CACHE_WAYS][`CACHE_SETS][`CACHE_LINE_WORDS];

    // line valid flags per way
    logic [`CACHE_SETS-1:0] valid_q [`CACHE_WAYS];

    // per set, the way to replace next
    logic [`CACHE_SETS-1:0] lru_q;

    cache_pkg::cache_addr_u req_addr;
    cache_pkg::cache_addr_u fill_addr;

    logic [`CACHE_INDEX_W-1:0]    req_idx;
    logic [`CACHE_TAG_W-1:0]      req_tag;
    logic [`CACHE_WORD_POS_W-1:0] req_word;
    logic [`CACHE_INDEX_W-1:0]    fill_idx;

    logic [`CACHE_WAYS-1:0] way_hit;
    logic                   hit_way;
    logic                   victim;
    logic                   rd_hit;
    logic                   wr_hit;
    logic                   fill_done;

    assign req_addr.flat  = mem_req.addr;
    assign fill_addr.flat = fill.base;

    assign req_idx  = req_addr.fields.set_idx;
    assign req_tag  = req_addr.fields.tag;
    assign req_word = req_addr.fields.word_off;
    assign fill_idx = fill_addr.fields.set_idx;

    // tag compare in both ways at once
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][req_idx] && (tag_mem[w][req_idx] == req_tag);
        end
    end

    assign hit      = mem_valid && (|way_hit);
    assign hit_way  = way_hit[1];
    assign hit_data = data_mem[hit_way][req_idx][req_word];

    assign rd_hit = hit && !mem_req.we;
    assign wr_hit = hit && mem_req.we;

    // lru is steady over a fill since no hit lands in a missing set
    assign victim    = lru_q[fill_idx];
    assign fill_done = fill.en && fill.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '{default: '0};
            lru_q   <= '0;
        end else begin
            if (rd_hit) begin
                // point away from the way just read
                lru_q[req_idx] <= ~hit_way;
            end
            if (fill_done) begin
                valid_q[victim][fill_idx] <= 1'b1;
                lru_q[fill_idx]           <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        // write hit keeps the cached copy in step with RAM
        if (wr_hit) begin
            data_mem[hit_way][req_idx][req_word] <= mem_req.w_data;
        end
        if (fill.en) begin
            data_mem[victim][fill_idx][fill.pos] <= fill.data;
        end
        // new tag lands with the last word
        if (fill_done) begin
            tag_mem[victim][fill_idx] <= fill_addr.fields.tag;
        end
    end

endmodule

// ==== mem_subsys_asserts.sv ====
`timescale 1ns/1ps

module mem_subsys_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   mem_valid,
    input cache_pkg::cpu_req_t    mem_req,
    input logic                   mem_ready,
    input logic                   cache_hit,
    input logic                   ram_we,
    input logic                   cnt_start,
    input cache_pkg::ctrl_state_t state
);

    // number of failed assertions
    int unsigned fail_count = 0;

    // response is a single-cycle pulse
    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        mem_ready |=> !mem_ready)
        else begin
            $error("mem_ready held high for two cycles");
            fail_count++;
        end

    // hit flag only travels with a response, and the requester has let go by then
    hit_with_ready: assert property (@(posedge clk) disable iff (rst)
        cache_hit |-> mem_ready && !mem_valid)
        else begin
            $error("cache_hit high without mem_ready or with mem_valid still held");
            fail_count++;
        end

    // no RAM write while a line is fetched, and the read request stays put
    no_write_in_fill: assert property (@(posedge clk) disable iff (rst)
        (state == cache_pkg::st_fill) |-> !ram_we && mem_valid && $stable(mem_req))
        else begin
            $error("ram_we high or request not held in fill state");
            fail_count++;
        end

    // four fill cycles then back to idle
    fill_length: assert property (@(posedge clk) disable iff (rst)
        cnt_start |=> (state == cache_pkg::st_fill) [*4] ##1 (state == cache_pkg::st_idle))
        else begin
            $error("fill did not last exactly four cycles");
            fail_count++;
        end

endmodule

bind cache_ctrl_fsm mem_subsys_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .cache_hit (cache_hit),
    .ram_we    (ram_we),
    .cnt_start (cnt_start),
    .state     (state)
);

// ==== mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module mem_subsys_tb;

    localparam int NUM_RANDOM     = 560;
    // directed plus random requests, up to 6 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + 40) * 6 + 400;

    logic                     clk;
    logic                     rst;
    logic                     mem_valid;
    cache_pkg::cpu_req_t      mem_req;
    logic [`CACHE_DATA_W-1:0] mem_r_data;
    logic                     mem_ready;
    logic                     cache_hit;

    // reference model of RAM and cache directory
    logic [`CACHE_DATA_W-1:0] ram_m   [`CACHE_RAM_WORDS];
    logic [`CACHE_TAG_W-1:0]  tag_m   [`CACHE_WAYS][`CACHE_SETS];
    logic                     valid_m [`CACHE_WAYS][`CACHE_SETS];
    logic                     lru_m   [`CACHE_SETS];

    int error_count;
    int check_count;
    int cycle_count;

    mem_subsys_top u_mem_subsys_top (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .mem_r_data (mem_r_data),
        .mem_ready  (mem_ready),
        .cache_hit  (cache_hit)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no finish after %0d cycles, DUT stopped answering", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    // one request issued and checked against the model
    task automatic access(input logic we, input logic [`CACHE_ADDR_W-1:0] addr,
                          input logic [`CACHE_DATA_W-1:0] wdata);
        int                       word;
        int                       idx;
        int                       hit_way;
        int                       lat;
        int                       exp_lat;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic                     found;
        logic                     exp_hit;
        logic                     victim;
        logic [`CACHE_DATA_W-1:0] exp_data;
        word    = addr[`CACHE_ADDR_W-1:`CACHE_BYTE_OFF_W];
        idx     = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        tag     = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        found   = 1'b0;
        hit_way = 0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid_m[w][idx] && tag_m[w][idx] == tag) begin
                found   = 1'b1;
                hit_way = w;
            end
        end
        exp_hit = 1'b0;
        exp_lat = 1;
        if (we) begin
            ram_m[word] = wdata;
        end else if (found) begin
            exp_hit    = 1'b1;
            lru_m[idx] = (hit_way == 0);
        end else begin
            // miss allocates into the way the LRU bit points at
            exp_lat              = 5;
            victim               = lru_m[idx];
            valid_m[victim][idx] = 1'b1;
            tag_m[victim][idx]   = tag;
            lru_m[idx]           = ~victim;
        end
        exp_data = ram_m[word];

        mem_req.we     = we;
        mem_req.addr   = addr;
        mem_req.w_data = wdata;
        mem_valid      = 1'b1;
        lat            = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!mem_ready);

        check_count++;
        if (lat != exp_lat) begin
            $display("Error at %0t: mem_ready latency addr %h expected %0d got %0d",
                     $time, addr, exp_lat, lat);
            error_count++;
        end
        if (cache_hit !== exp_hit) begin
            $display("Error at %0t: cache_hit addr %h expected %b got %b",
                     $time, addr, exp_hit, cache_hit);
            error_count++;
        end
        if (!we && mem_r_data !== exp_data) begin
            $display("Error at %0t: mem_r_data addr %h expected %h got %h",
                     $time, addr, exp_data, mem_r_data);
            error_count++;
        end
        #1;
        mem_valid = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        mem_valid   = 1'b0;
        mem_req     = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        void'($urandom(26025));
        for (int i = 0; i < `CACHE_RAM_WORDS; i++) begin
            ram_m[i] = '0;
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            lru_m[s] = 1'b0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_m[w][s] = 1'b0;
                tag_m[w][s]   = '0;
            end
        end

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        if (mem_ready !== 1'b0 || cache_hit !== 1'b0) begin
            $display("Error at %0t: mem_ready/cache_hit expected 0/0 got %b/%b",
                     $time, mem_ready, cache_hit);
            error_count++;
        end

        // cold misses read zero
        access(1'b0, 12'h000, '0);
        access(1'b0, 12'h104, '0);
        access(1'b0, 12'hffc, '0);

        // miss then hits across the whole line
        access(1'b0, 12'h040, '0);
        for (int k = 0; k < `CACHE_LINE_WORDS; k++) begin
            access(1'b0, 12'h040 + 12'(k * 4), '0);
        end

        // write-through on a cached and an uncached line
        access(1'b1, 12'h044, 32'hcafe_0044);
        access(1'b0, 12'h044, '0);
        access(1'b0, 12'h048, '0);
        access(1'b1, 12'h380, 32'h1234_5678);
        access(1'b0, 12'h380, '0);
        access(1'b0, 12'h384, '0);

        // three tags in set 3
        access(1'b0, 12'h030, '0);
        access(1'b0, 12'h230, '0);
        access(1'b0, 12'h430, '0);
        access(1'b0, 12'h030, '0);
        access(1'b0, 12'h230, '0);

        // random mix with about 40 percent writes
        for (int n = 0; n < NUM_RANDOM; n++) begin
            access(($urandom % 100) < 40, 12'(($urandom % `CACHE_RAM_WORDS) * 4), $urandom);
        end

        // failed bound assertions count as errors
        error_count += u_mem_subsys_top.u_ctrl.u_asserts.fail_count;

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module mem_subsys_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_valid,
    input  cache_pkg::cpu_req_t      mem_req,
    output logic [`CACHE_DATA_W-1:0] mem_r_data,
    output logic                     mem_ready,
    output logic                     cache_hit
);

    // cache lookup result
    logic                     hit;
    logic [`CACHE_DATA_W-1:0] hit_data;

    // controller to cache fill path
    cache_pkg::fill_t fill;

    // fill counter handshake
    logic                         cnt_start;
    logic                         cnt_step;
    logic [`CACHE_WORD_POS_W-1:0] word_pos;
    logic                         last;

    // RAM port
    logic [`CACHE_ADDR_W-1:0] ram_addr;
    logic                     ram_we;
    logic [`CACHE_DATA_W-1:0] ram_w_data;
    logic [`CACHE_DATA_W-1:0] ram_r_data;

    cache_ctrl_fsm u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .hit        (hit),
        .hit_data   (hit_data),
        .ram_r_data (ram_r_data),
        .word_pos   (word_pos),
        .last       (last),
        .cnt_start  (cnt_start),
        .cnt_step   (cnt_step),
        .fill       (fill),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_w_data (ram_w_data),
        .mem_r_data (mem_r_data),
        .mem_ready  (mem_ready),
        .cache_hit  (cache_hit)
    );

    fill_counter u_cnt (
        .clk      (clk),
        .rst      (rst),
        .start    (cnt_start),
        .step     (cnt_step),
        .word_pos (word_pos),
        .last     (last)
    );

    l1_cache_2way u_l1 (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .hit       (hit),
        .hit_data  (hit_data),
        .fill      (fill)
    );

    backing_ram u_ram (
        .clk    (clk),
        .addr   (ram_addr),
        .we     (ram_we),
        .w_data (ram_w_data),
        .r_data (ram_r_data)
    );

endmodule

// ==== src.f ====
+incdir+.
cache_pkg.sv
fill_counter.sv
cache_ctrl_fsm.sv
l1_cache_2way.sv
backing_ram.sv
mem_subsys_top.sv
mem_subsys_asserts.sv
mem_subsys_tb.sv
